// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tbPortal -f portal.f -o simPortal

run: compile
	@out=$$(./obj_dir/simPortal); echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir

// File: beatIf.sv
// one word beat of a split burst
interface beatIf;
  logic                              valid;
  logic [portalPkg::offsetWidth-1:0] offset;
  logic [portalPkg::idWidth-1:0]     id;
  logic                              last;
  portalPkg::portalSel_e             portal;
  logic                              ctrlPage;  // bits 11..5 were zero
  logic                              ready;

  modport source (
    output valid, offset, id, last, portal, ctrlPage,
    input  ready
  );

  modport sink (
    input  valid, offset, id, last, portal, ctrlPage,
    output ready
  );

endinterface

// File: burstSplitter.sv
module burstSplitter (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            cmdValid,
  output logic                            cmdReady,
  input  logic [portalPkg::addrWidth-1:0] cmdAddr,
  input  logic [portalPkg::lenWidth-1:0]  cmdLen,
  input  logic [portalPkg::idWidth-1:0]   cmdId,
  beatIf.source                           beat
);
  localparam int offsetWidth = portalPkg::offsetWidth;
  localparam int addrWidth   = portalPkg::addrWidth;

  logic                              busy;
  logic [portalPkg::lenWidth-1:0]    remain;  // beats left after this one
  logic                              beatFire;
  logic                              cmdFire;

  assign beatFire   = beat.valid && beat.ready;
  assign cmdReady   = !busy || (beatFire && beat.last);  // back to back bursts
  assign cmdFire    = cmdValid && cmdReady;
  assign beat.valid = busy;
  assign beat.last  = (remain == '0);

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      busy <= 1'b0;
    end else if (cmdFire) begin
      busy <= 1'b1;
    end else if (beatFire && beat.last) begin
      busy <= 1'b0;
    end
  end

  // decode portal and page once per burst
  always_ff @(posedge CLK) begin
    if (cmdFire) begin
      beat.offset   <= cmdAddr[offsetWidth-1:0];
      beat.id       <= cmdId;
      beat.portal   <= portalPkg::portalSel_e'(cmdAddr[addrWidth-1]);
      beat.ctrlPage <= (cmdAddr[addrWidth-2:offsetWidth] == '0);
      remain        <= cmdLen;
    end else if (beatFire) begin
      beat.offset <= beat.offset + offsetWidth'(portalPkg::wordBytes);  // wraps mod 32
      remain      <= remain - 1'b1;
    end
  end

endmodule

// File: ctrlRegs.sv
module ctrlRegs (
  input  logic                            CLK,
  input  logic                            nRST,
  input  portalPkg::ctrlReg_e             rdOffset,
  input  portalPkg::portalSel_e           rdPortal,
  output logic [portalPkg::dataWidth-1:0] rdData,
  input  logic                            wrEn,
  input  portalPkg::ctrlReg_e             wrOffset,
  input  logic [portalPkg::dataWidth-1:0] wrData,
  input  logic                            indValid,
  output logic                            interrupt
);
  localparam int dataWidth = portalPkg::dataWidth;

  logic intEnable;
  logic pending;  // indication word waiting

  assign pending   = (rdPortal == portalPkg::indPortal) && indValid;
  assign interrupt = indValid && intEnable;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      intEnable <= 1'b0;
    end else if (wrEn && (wrOffset == portalPkg::ctrlIntEnable)) begin
      intEnable <= wrData[0];
    end
  end

  always_comb begin
    case (rdOffset)
      portalPkg::ctrlIntStatus:   rdData = dataWidth'(pending);
      portalPkg::ctrlNumTiles:    rdData = portalPkg::numTiles;
      portalPkg::ctrlQueueStatus: rdData = dataWidth'(pending);
      portalPkg::ctrlNumPortals:  rdData = portalPkg::numPortals;
      portalPkg::ctrlPortalId: begin
        if (rdPortal == portalPkg::indPortal) begin
          rdData = portalPkg::indPortalId;
        end else begin
          rdData = portalPkg::reqPortalId;
        end
      end
      default: rdData = portalPkg::ctrlFiller;  // enable offset lands here too
    endcase
  end

endmodule

// File: portal.f
portalPkg.sv
beatIf.sv
portalFifo.sv
burstSplitter.sv
ctrlRegs.sv
readPath.sv
writePath.sv
portalTop.sv
tbPortal.sv

// File: portalFifo.sv
module portalFifo #(
  parameter int width = 32,
  parameter int depth = 2
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             enq,
  input  logic [width-1:0] dIn,
  input  logic             deq,
  output logic [width-1:0] dOut,
  output logic             full,
  output logic             empty
);
  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntWidth = $clog2(depth + 1);

  logic [width-1:0]    mem [depth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [cntWidth-1:0] count;
  logic                doEnq;
  logic                doDeq;

  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] p);
    return (p == ptrWidth'(depth - 1)) ? '0 : p + 1'b1;  // wrap for any depth
  endfunction

  assign full  = (count == cntWidth'(depth));
  assign empty = (count == '0);
  assign doEnq = enq && !full;
  assign doDeq = deq && !empty;
  assign dOut  = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (doEnq) begin
      mem[wrPtr] <= dIn;
    end
  end

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doEnq) wrPtr <= nextPtr(wrPtr);
      if (doDeq) rdPtr <= nextPtr(rdPtr);
      case ({doEnq, doDeq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

// File: portalPkg.sv
package portalPkg;

  // bus and beat geometry
  localparam int addrWidth   = 13;
  localparam int dataWidth   = 32;
  localparam int idWidth     = 6;
  localparam int lenWidth    = 4;  // beats minus one
  localparam int offsetWidth = 5;
  localparam int wordBytes   = 4;

  // address bit 12
  typedef enum logic {
    reqPortal = 1'b0,
    indPortal = 1'b1
  } portalSel_e;

  typedef enum logic [offsetWidth-1:0] {
    ctrlIntStatus   = 5'd0,
    ctrlIntEnable   = 5'd4,
    ctrlNumTiles    = 5'd8,
    ctrlQueueStatus = 5'd12,
    ctrlPortalId    = 5'd16,
    ctrlNumPortals  = 5'd20
  } ctrlReg_e;

  localparam logic [dataWidth-1:0] numTiles    = 32'd1;
  localparam logic [dataWidth-1:0] numPortals  = 32'd2;
  localparam logic [dataWidth-1:0] reqPortalId = 32'd5;
  localparam logic [dataWidth-1:0] indPortalId = 32'd6;
  localparam logic [dataWidth-1:0] ctrlFiller  = 32'h005A05A0;  // unlisted ctrl offsets

  // user page layout
  localparam logic [offsetWidth-1:0] userDataOffset  = 5'd0;
  localparam logic [offsetWidth-1:0] userSpaceOffset = 5'd4;

endpackage

// File: portalTop.sv
module portalTop #(
  parameter int readDepth  = 2,
  parameter int writeDepth = 2
) (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            arValid,
  output logic                            arReady,
  input  logic [portalPkg::addrWidth-1:0] arAddr,
  input  logic [portalPkg::lenWidth-1:0]  arLen,
  input  logic [portalPkg::idWidth-1:0]   arId,
  output logic                            rValid,
  input  logic                            rReady,
  output logic [portalPkg::dataWidth-1:0] rData,
  output logic [portalPkg::idWidth-1:0]   rId,
  output logic                            rLast,
  input  logic                            awValid,
  output logic                            awReady,
  input  logic [portalPkg::addrWidth-1:0] awAddr,
  input  logic [portalPkg::lenWidth-1:0]  awLen,
  input  logic [portalPkg::idWidth-1:0]   awId,
  input  logic                            wValid,
  output logic                            wReady,
  input  logic [portalPkg::dataWidth-1:0] wData,
  input  logic                            wLast,
  output logic                            bValid,
  input  logic                            bReady,
  output logic [portalPkg::idWidth-1:0]   bId,
  output logic [1:0]                      bResp,
  output logic                            reqValid,
  input  logic                            reqReady,
  output logic [portalPkg::dataWidth-1:0] reqData,
  input  logic                            indValid,
  output logic                            indReady,
  input  logic [portalPkg::dataWidth-1:0] indData,
  output logic                            interrupt
);
  portalPkg::ctrlReg_e             ctrlOffset;
  portalPkg::portalSel_e           ctrlPortal;
  logic [portalPkg::dataWidth-1:0] ctrlData;
  logic                            ctrlWrEn;
  portalPkg::ctrlReg_e             ctrlWrOffset;
  logic [portalPkg::dataWidth-1:0] ctrlWrData;

  readPath #(.readDepth(readDepth)) rdPath (
    .CLK(CLK), .nRST(nRST),
    .arValid(arValid), .arReady(arReady), .arAddr(arAddr), .arLen(arLen), .arId(arId),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
    .indValid(indValid), .indReady(indReady), .indData(indData), .reqReady(reqReady),
    .ctrlOffset(ctrlOffset), .ctrlPortal(ctrlPortal), .ctrlData(ctrlData)
  );

  writePath #(.writeDepth(writeDepth)) wrPath (
    .CLK(CLK), .nRST(nRST),
    .awValid(awValid), .awReady(awReady), .awAddr(awAddr), .awLen(awLen), .awId(awId),
    .wValid(wValid), .wReady(wReady), .wData(wData), .wLast(wLast),
    .bValid(bValid), .bReady(bReady), .bId(bId), .bResp(bResp),
    .reqValid(reqValid), .reqReady(reqReady), .reqData(reqData),
    .ctrlWrEn(ctrlWrEn), .ctrlWrOffset(ctrlWrOffset), .ctrlWrData(ctrlWrData)
  );

  // shared control page, read side muxed by the read beat's portal
  ctrlRegs ctrl (
    .CLK(CLK), .nRST(nRST),
    .rdOffset(ctrlOffset), .rdPortal(ctrlPortal), .rdData(ctrlData),
    .wrEn(ctrlWrEn), .wrOffset(ctrlWrOffset), .wrData(ctrlWrData),
    .indValid(indValid), .interrupt(interrupt)
  );

endmodule

// File: readPath.sv
module readPath #(
  parameter int readDepth = 2
) (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            arValid,
  output logic                            arReady,
  input  logic [portalPkg::addrWidth-1:0] arAddr,
  input  logic [portalPkg::lenWidth-1:0]  arLen,
  input  logic [portalPkg::idWidth-1:0]   arId,
  output logic                            rValid,
  input  logic                            rReady,
  output logic [portalPkg::dataWidth-1:0] rData,
  output logic [portalPkg::idWidth-1:0]   rId,
  output logic                            rLast,
  input  logic                            indValid,
  output logic                            indReady,
  input  logic [portalPkg::dataWidth-1:0] indData,
  input  logic                            reqReady,
  output portalPkg::ctrlReg_e             ctrlOffset,
  output portalPkg::portalSel_e           ctrlPortal,
  input  logic [portalPkg::dataWidth-1:0] ctrlData
);
  localparam int dataWidth = portalPkg::dataWidth;
  localparam int qWidth    = dataWidth + portalPkg::idWidth + 1;

  logic                 qFull;
  logic                 qEmpty;
  logic                 beatFire;
  logic                 indSlot;   // indication data register
  logic                 reqSlot;   // request space register
  logic [dataWidth-1:0] word;
  logic [qWidth-1:0]    qIn;
  logic [qWidth-1:0]    qOut;

  beatIf rdBeat ();

  burstSplitter splitter (
    .CLK      (CLK),
    .nRST     (nRST),
    .cmdValid (arValid),
    .cmdReady (arReady),
    .cmdAddr  (arAddr),
    .cmdLen   (arLen),
    .cmdId    (arId),
    .beat     (rdBeat.source)
  );

  assign rdBeat.ready = !qFull;
  assign beatFire     = rdBeat.valid && rdBeat.ready;

  assign indSlot = !rdBeat.ctrlPage && (rdBeat.portal == portalPkg::indPortal)
                   && (rdBeat.offset == portalPkg::userDataOffset);
  assign reqSlot = !rdBeat.ctrlPage && (rdBeat.portal == portalPkg::reqPortal)
                   && (rdBeat.offset == portalPkg::userSpaceOffset);

  assign ctrlOffset = portalPkg::ctrlReg_e'(rdBeat.offset);
  assign ctrlPortal = rdBeat.portal;
  assign indReady   = beatFire && indSlot;  // pop only when the beat is queued

  always_comb begin
    if (rdBeat.ctrlPage) begin
      word = ctrlData;
    end else if (indSlot) begin
      word = indValid ? indData : '0;
    end else if (reqSlot) begin
      word = dataWidth'(reqReady);
    end else begin
      word = '0;
    end
  end

  assign qIn = {word, rdBeat.id, rdBeat.last};

  portalFifo #(
    .width (qWidth),
    .depth (readDepth)
  ) readQueue (
    .CLK   (CLK),
    .nRST  (nRST),
    .enq   (beatFire),
    .dIn   (qIn),
    .deq   (rValid && rReady),
    .dOut  (qOut),
    .full  (qFull),
    .empty (qEmpty)
  );

  assign rValid              = !qEmpty;
  assign {rData, rId, rLast} = qOut;

endmodule

// File: tbPortal.sv
module tbPortal;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int maxCycles = 4000;  // five short tests need a few hundred

  logic                            CLK = 1'b0;
  logic                            nRST;
  logic                            arValid, arReady, awValid, awReady, wValid, wReady, wLast;
  logic                            rValid, rReady, rLast, bValid, bReady;
  logic                            reqValid, reqReady, indValid, indReady, interrupt;
  logic [portalPkg::addrWidth-1:0] arAddr, awAddr;
  logic [portalPkg::lenWidth-1:0]  arLen, awLen;
  logic [portalPkg::idWidth-1:0]   arId, rId, awId, bId;
  logic [portalPkg::dataWidth-1:0] rData, wData, reqData, indData;
  logic [1:0]                      bResp;

  logic [31:0] lfsr = 32'h30ab_4859;
  int          cycles = 0;
  int          errCount = 0;
  int          passCount = 0;
  int          failCount = 0;
  int          rCount = 0;
  int          reqCount = 0;
  logic        enModel = 1'b0;     // last enable bit written
  logic        ctrlWrBusy = 1'b0;  // control write in flight
  logic        indTaken = 1'b0;
  logic [31:0] expData[$];
  logic [5:0]  expId[$];
  logic        expLast[$];
  logic [31:0] expReq[$];
  logic [5:0]  expB[$];
  logic [31:0] indPending[$];  // words offered on the indication port
  logic [31:0] indExpect[$];
  logic [31:0] wrWords[$];
  logic [31:0] reqWords[$];

  portalTop #(.readDepth(2), .writeDepth(2)) i_dut (.*);

  always #10 CLK = ~CLK;

  function automatic logic nextRandomBit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  function automatic logic [31:0] randomWord();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) begin
      w[i] = nextRandomBit();
    end
    return w;
  endfunction

  // word for beat k of a read at addr
  function automatic logic [31:0] expectedWord(input logic [12:0] addr, input int k);
    logic [4:0] offset;
    logic       ind;
    offset = addr[4:0] + 5'(4 * k);
    ind = addr[12];
    if (addr[11:5] != 7'd0) begin
      if (ind && offset == 5'd0 && indExpect.size() > 0) begin
        return indExpect.pop_front();
      end
      return 32'd0;  // space slot follows reqReady, not read here
    end
    case (offset)
      5'd0, 5'd12: return {31'd0, ind && indExpect.size() > 0};
      5'd8:        return 32'd1;
      5'd16:       return ind ? 32'd6 : 32'd5;
      5'd20:       return 32'd2;
      default:     return 32'h005A_05A0;
    endcase
  endfunction

  task automatic checkEq(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      errCount++;
      $display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic flagUnexpected(input string msg);
    errCount++;
    $display("%0t %s", $time, msg);
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge CLK);
    #2;
  endtask

  task automatic waitReady(input int ch);  // 0 AR, 1 AW, 2 W
    logic fired;
    do begin
      @(negedge CLK);
      case (ch)
        0:       fired = arReady;
        1:       fired = awReady;
        default: fired = wReady;
      endcase
      @(posedge CLK);
      #2;
    end while (!fired);
  endtask

  task automatic drain();
    do begin
      @(posedge CLK);
      #2;
    end while (expData.size() > 0 || expB.size() > 0 || expReq.size() > 0);
  endtask

  task automatic issueRead(input logic [12:0] addr, input logic [3:0] len,
                           input logic [5:0] id);
    arAddr = addr;
    arLen = len;
    arId = id;
    arValid = 1'b1;
    waitReady(0);
    arValid = 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      expData.push_back(expectedWord(addr, k));
      expId.push_back(id);
      expLast.push_back(k == int'(len));
    end
  endtask

  task automatic writeBurst(input logic [12:0] addr, input logic [5:0] id);
    ctrlWrBusy = (addr[11:5] == 7'd0);
    if (!addr[12] && !ctrlWrBusy) begin
      foreach (wrWords[i]) expReq.push_back(wrWords[i]);
    end
    expB.push_back(id);
    awAddr = addr;
    awLen = 4'(wrWords.size() - 1);
    awId = id;
    awValid = 1'b1;
    waitReady(1);
    awValid = 1'b0;
    foreach (wrWords[i]) begin
      wValid = 1'b1;
      wData = wrWords[i];
      wLast = (i == wrWords.size() - 1);
      waitReady(2);
    end
    wValid = 1'b0;
    wLast = 1'b0;
    drain();
    foreach (wrWords[i]) begin
      if (ctrlWrBusy && 5'(addr[4:0] + 5'(4 * i)) == 5'd4) enModel = wrWords[i][0];
    end
    ctrlWrBusy = 1'b0;
  endtask

  task automatic endTest(input string name, input int errBefore);
    if (errCount == errBefore) begin
      passCount++;
      $display("test %s: ok", name);
    end else begin
      failCount++;
      $display("test %s: %0d errors", name, errCount - errBefore);
    end
  endtask

  // user side and ready toggling
  always @(posedge CLK) begin
    #2;
    if (indTaken) indPending.delete(0);
    indValid = (indPending.size() > 0);
    indData = indValid ? indPending[0] : 32'd0;
    rReady = nextRandomBit();
    bReady = nextRandomBit();
    reqReady = nextRandomBit();
  end

  always @(negedge CLK) begin
    indTaken = indValid && indReady;
    if (nRST && rValid && rReady) begin
      rCount++;
      if (expData.size() == 0) begin
        flagUnexpected("an R beat arrived with no read outstanding");
      end else begin
        checkEq("rData", expData.pop_front(), rData);
        checkEq("rId", 32'(expId.pop_front()), 32'(rId));
        checkEq("rLast", 32'(expLast.pop_front()), 32'(rLast));
      end
    end
    if (nRST && bValid && bReady) begin
      if (expB.size() == 0) begin
        flagUnexpected("a write response arrived with no write outstanding");
      end else begin
        checkEq("bId", 32'(expB.pop_front()), 32'(bId));
        checkEq("bResp", 32'd0, 32'(bResp));
      end
    end
    if (nRST && reqValid) begin
      if (reqReady) reqCount++;
      if (expReq.size() == 0) begin
        flagUnexpected("reqValid was raised with no request write outstanding");
      end else if (reqReady) begin
        checkEq("reqData", expReq.pop_front(), reqData);
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= maxCycles) begin
      $display("run stopped after %0d cycles with traffic still pending", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // enable bit is only known once the control write's B is back
  assert property (@(posedge CLK) disable iff (!nRST || ctrlWrBusy)
      interrupt == (indValid && enModel))
    else begin
      errCount++;
      $display("ERROR %0t interrupt expected %0b actual %0b", $time,
               $sampled(indValid) && $sampled(enModel), $sampled(interrupt));
    end

  assert property (@(posedge CLK) disable iff (!nRST)
      rValid && !rReady |=> rValid && $stable(rData))
    else begin
      errCount++;
      $display("ERROR %0t rValid/rData expected 1/%h actual %0b/%h", $time,
               $past(rData), $sampled(rValid), $sampled(rData));
    end

  assert property (@(posedge CLK) $rose(nRST) |-> !(rValid || bValid || reqValid || interrupt))
    else begin
      errCount++;
      $display("ERROR %0t rValid/bValid/reqValid/interrupt expected 0000 actual %b", $time,
               {$sampled(rValid), $sampled(bValid), $sampled(reqValid), $sampled(interrupt)});
    end

  initial begin
    int errBefore;
    int countBefore;
    int offs[4] = '{8, 20, 16, 24};
    nRST = 1'b0;
    {arValid, awValid, wValid, wLast, rReady, bReady, reqReady, indValid} = '0;
    arAddr = '0;
    arLen = '0;
    arId = '0;
    awAddr = '0;
    awLen = '0;
    awId = '0;
    wData = '0;
    indData = '0;
    repeat (4) reqWords.push_back(randomWord());
    repeat (16) @(posedge CLK);
    #2;
    nRST = 1'b1;
    idle(2);

    errBefore = errCount;
    for (int p = 0; p < 2; p++) begin
      foreach (offs[i]) issueRead({p[0], 7'd0, 5'(offs[i])}, 4'd0, 6'(i + 1));
    end
    drain();
    endTest("control page reads", errBefore);

    errBefore = errCount;
    countBefore = reqCount;
    wrWords = reqWords;
    writeBurst(13'h0020, 6'h11);
    idle(4);
    checkEq("request beat count", 32'd4, 32'(reqCount - countBefore));
    wrWords.delete();
    wrWords.push_back(32'h0000_00ff);
    writeBurst(13'h0018, 6'h12);  // control page, no request word
    idle(4);
    endTest("request portal write burst", errBefore);

    errBefore = errCount;
    indPending.push_back(32'hA5A5_0001);
    indExpect.push_back(32'hA5A5_0001);
    idle(2);
    wrWords.delete();
    wrWords.push_back(32'd1);
    writeBurst(13'h1004, 6'h21);
    @(negedge CLK);
    checkEq("interrupt", 32'd1, 32'(interrupt));
    idle(1);
    issueRead(13'h1000, 4'd0, 6'h22);
    drain();
    wrWords.delete();
    wrWords.push_back(32'd0);
    writeBurst(13'h1004, 6'h23);
    @(negedge CLK);
    checkEq("interrupt", 32'd0, 32'(interrupt));
    idle(1);
    endTest("interrupt enable", errBefore);

    errBefore = errCount;
    indPending.push_back(32'h5A5A_0002);
    indExpect.push_back(32'h5A5A_0002);
    idle(2);
    issueRead(13'h1020, 4'd2, 6'h31);  // offsets 0, 4, 8
    drain();
    issueRead(13'h1038, 4'd2, 6'h32);  // offsets 24, 28, 0
    drain();
    issueRead(13'h1020, 4'd0, 6'h33);
    drain();
    endTest("indication portal read burst", errBefore);

    errBefore = errCount;
    countBefore = rCount;
    issueRead(13'h0000, 4'd3, 6'h03);
    issueRead(13'h1008, 4'd5, 6'h04);
    drain();
    idle(4);
    checkEq("R beat count", 32'd10, 32'(rCount - countBefore));
    endTest("back-to-back reads", errBefore);

    $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
    if (errCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: writePath.sv
module writePath #(
  parameter int writeDepth = 2
) (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            awValid,
  output logic                            awReady,
  input  logic [portalPkg::addrWidth-1:0] awAddr,
  input  logic [portalPkg::lenWidth-1:0]  awLen,
  input  logic [portalPkg::idWidth-1:0]   awId,
  input  logic                            wValid,
  output logic                            wReady,
  input  logic [portalPkg::dataWidth-1:0] wData,
  input  logic                            wLast,
  output logic                            bValid,
  input  logic                            bReady,
  output logic [portalPkg::idWidth-1:0]   bId,
  output logic [1:0]                      bResp,
  output logic                            reqValid,
  input  logic                            reqReady,
  output logic [portalPkg::dataWidth-1:0] reqData,
  output logic                            ctrlWrEn,
  output portalPkg::ctrlReg_e             ctrlWrOffset,
  output logic [portalPkg::dataWidth-1:0] ctrlWrData
);
  localparam int dataWidth = portalPkg::dataWidth;
  localparam int idWidth   = portalPkg::idWidth;

  logic                 lastSeen;  // wLast taken, wait for next AW
  logic                 awFire;
  logic                 wFire;
  logic                 wFull;
  logic                 wEmpty;
  logic [dataWidth-1:0] wHead;
  logic                 bFull;
  logic                 bEmpty;
  logic                 toReq;
  logic                 respOk;
  logic                 beatFire;

  beatIf wrBeat ();

  burstSplitter splitter (
    .CLK      (CLK),
    .nRST     (nRST),
    .cmdValid (awValid),
    .cmdReady (awReady),
    .cmdAddr  (awAddr),
    .cmdLen   (awLen),
    .cmdId    (awId),
    .beat     (wrBeat.source)
  );

  assign awFire = awValid && awReady;
  assign wReady = !lastSeen && !wFull;
  assign wFire  = wValid && wReady;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      lastSeen <= 1'b1;  // no W before the first AW
    end else if (awFire) begin
      lastSeen <= 1'b0;
    end else if (wFire && wLast) begin
      lastSeen <= 1'b1;
    end
  end

  portalFifo #(
    .width (dataWidth),
    .depth (writeDepth)
  ) dataQueue (
    .CLK   (CLK),
    .nRST  (nRST),
    .enq   (wFire),
    .dIn   (wData),
    .deq   (beatFire),
    .dOut  (wHead),
    .full  (wFull),
    .empty (wEmpty)
  );

  // pair the beat with the head W word
  assign toReq  = !wrBeat.ctrlPage && (wrBeat.portal == portalPkg::reqPortal);
  assign respOk = !wrBeat.last || !bFull;

  assign reqValid     = wrBeat.valid && !wEmpty && respOk && toReq;
  assign reqData      = wHead;
  assign wrBeat.ready = !wEmpty && respOk && (!toReq || reqReady);
  assign beatFire     = wrBeat.valid && wrBeat.ready;

  assign ctrlWrEn     = beatFire && wrBeat.ctrlPage;
  assign ctrlWrOffset = portalPkg::ctrlReg_e'(wrBeat.offset);
  assign ctrlWrData   = wHead;

  portalFifo #(
    .width (idWidth),
    .depth (writeDepth)
  ) respQueue (
    .CLK   (CLK),
    .nRST  (nRST),
    .enq   (beatFire && wrBeat.last),  // one B per burst
    .dIn   (wrBeat.id),
    .deq   (bValid && bReady),
    .dOut  (bId),
    .full  (bFull),
    .empty (bEmpty)
  );

  assign bValid = !bEmpty;
  assign bResp  = 2'b00;  // always OKAY

endmodule
